// File: src.f
rtl/game_pkg.sv
rtl/vga_if.sv
rtl/cursor_draw.sv
rtl/gloves_draw.sv
rtl/keeper_pos_tx.sv
rtl/mouse_control.sv
rtl/keeper_view_top.sv
tb/keeper_view_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := keeper_view_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run from the project root so the trace path resolves
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

// File: tb/keeper_trace.txt
# hcount vcount hsync vsync hblnk vblnk rgb xpos ypos state tx_full op | exp: rgb hsync tx_wr tx_data
# Video expectations appear 3 cycles later, tx expectations in the same cycle, - skips a check
5DB 010 0 0 0 0 100 5DC 010 1 1 0 100 0 0 00
5DC 010 0 0 0 0 101 5DC 010 1 0 0 FFF 0 0 00
5E3 017 0 0 0 0 102 5DC 010 1 0 0 FFF 0 1 F9
5E4 010 0 0 0 0 103 5DC 010 1 1 0 103 0 0 F9
5DE 012 0 0 1 0 104 5DC 010 1 1 0 104 0 0 F9
2A5 018 0 0 0 0 105 2A5 010 1 0 0 105 0 0 F9
2A8 013 1 0 0 1 106 2A5 010 1 0 0 106 1 1 FA
2A9 013 1 0 0 0 107 2A5 010 1 1 0 FFF 1 0 FA
2AC 015 0 0 0 0 108 2A5 010 1 1 0 FFF 0 0 FA
2A7 012 0 0 0 0 109 2A5 010 1 1 0 FFF 0 0 FA
2A7 012 0 0 0 0 10A 2A5 010 1 1 0 FA0 0 0 FA
2A6 011 0 0 0 0 10B 2A5 010 1 1 0 10B 0 0 FA
2AC 014 0 0 0 0 10C 2A5 010 2 1 0 10C 0 0 FA
2AD 014 0 0 0 0 10D 2A5 010 2 1 0 10D 0 0 FA
2AE 014 0 0 0 0 10E 2A5 010 2 0 0 FA0 0 0 FA
2B3 01D 0 0 0 0 10F 2A5 010 2 0 0 FA0 0 1 29
2B4 01E 0 0 0 0 110 2A5 010 2 1 0 110 0 0 29
0C3 01F 0 0 0 0 111 0C3 010 2 0 0 111 0 0 29
0C4 019 0 0 0 0 112 0C3 010 2 0 0 FA0 0 1 AA
0D2 01A 0 0 0 0 113 0C3 010 2 1 0 113 0 0 AA
0D3 012 0 0 0 0 114 0C3 010 2 0 0 114 0 0 AA
0C8 012 0 0 1 0 115 0C3 010 2 0 7 115 0 1 19
0C9 020 0 0 0 0 116 0C3 010 2 1 0 116 0 0 19
156 012 0 0 0 0 117 155 010 2 0 0 FA0 0 0 19
15B 01D 0 0 0 0 118 155 010 2 0 0 FA0 - 1 A9
15C 01D 0 0 0 0 119 155 010 2 1 0 119 0 0 A9
156 012 0 0 0 0 11A 155 010 2 0 0 FFF 0 0 -
15E 012 0 0 0 0 11B 155 010 2 0 0 11B 0 1 52
154 013 0 0 0 0 11C 155 010 1 1 0 11C 0 0 52
15C 017 0 0 0 0 11D 155 010 1 1 0 FFF 0 0 52
15C 018 0 0 0 0 11E 155 010 1 1 0 11E 0 0 52
159 014 0 1 0 0 11F 155 010 1 1 0 FFF 0 0 52
159 014 0 0 0 1 120 155 010 1 1 0 120 0 0 52
000 000 1 0 0 0 000 155 010 1 1 0 000 1 0 52

// File: tb/keeper_view_tb.sv
/* Trace driven testbench for keeper_view_top, run from the project root.
   Expects CURSOR_SIZE 8 and GLOVES_SIZE 16 and at most 64 trace rows */

`timescale 1ns/1ps

module keeper_view_tb;

    localparam int    MAX_ROWS = 64;
    localparam int    CSIZE    = 8;
    localparam string TRACE    = "tb/keeper_trace.txt";

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [10:0] hcount_in = '0, vcount_in = '0;
    logic        hsync_in = 1'b0, vsync_in = 1'b0, hblnk_in = 1'b0, vblnk_in = 1'b0;
    logic [11:0] rgb_in = '0;
    logic [11:0] xpos = '0, ypos = '0;
    game_pkg::g_state game_state = game_pkg::MENU;
    logic        tx_full = 1'b1;  // Keeps the sender idle until the trace starts
    logic [2:0]  op_code_data = '0;
    logic [10:0] hcount_out, vcount_out;
    logic        hsync_out, vsync_out, hblnk_out, vblnk_out;
    logic [11:0] rgb_out;
    logic [7:0]  tx_data;
    logic        tx_wr;

    // Trace rows
    logic [31:0] t_in [MAX_ROWS][12];
    logic [31:0] t_exp [MAX_ROWS][4];
    logic        t_chk [MAX_ROWS][4];
    int          n_rows = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit  = 0;

    keeper_view_top #(
        .CURSOR_SIZE(8),
        .GLOVES_SIZE(16)
    ) uut (
        .clk, .rst,
        .hcount_in, .vcount_in, .hsync_in, .vsync_in, .hblnk_in, .vblnk_in, .rgb_in,
        .xpos, .ypos, .game_state, .tx_full, .op_code_data,
        .hcount_out, .vcount_out, .hsync_out, .vsync_out, .hblnk_out, .vblnk_out,
        .rgb_out, .tx_data, .tx_wr
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            errors = errors + 1;
            report_and_finish();
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            errors = errors + 1;
        end
    endtask

    task automatic report_and_finish;
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    function automatic logic [31:0] hex_value(input logic [63:0] tok);
        logic [31:0] val;
        logic [7:0]  ch;
        val = '0;
        for (int i = 7; i >= 0; i--) begin
            ch = tok[i*8 +: 8];
            if (ch >= 8'h30 && ch <= 8'h39)
                val = (val << 4) | 32'(ch - 8'h30);
            else if (ch >= 8'h41 && ch <= 8'h46)
                val = (val << 4) | 32'(ch - 8'h37);
            else if (ch >= 8'h61 && ch <= 8'h66)
                val = (val << 4) | 32'(ch - 8'h57);
        end
        return val;
    endfunction

    // Independent cursor model, square of CSIZE at (xpos, ypos)
    function automatic logic [31:0] cursor_rule(input int p);
        logic in_sq;
        in_sq = t_in[p][0] >= t_in[p][7] && t_in[p][0] < t_in[p][7] + CSIZE &&
                t_in[p][1] >= t_in[p][8] && t_in[p][1] < t_in[p][8] + CSIZE &&
                t_in[p][4] == 0 && t_in[p][5] == 0;
        return in_sq ? 32'hFFF : t_in[p][6];
    endfunction

    task automatic load_trace(input int fd);
        logic [8*200-1:0] line;
        logic [31:0]      c [12];
        logic [63:0]      tk [4];
        int               got;
        while (!$feof(fd) && n_rows < MAX_ROWS) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %s %s %s %s",
                              c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
                              c[10], c[11], tk[0], tk[1], tk[2], tk[3]);
                if (got == 16) begin  // Comment and blank lines fall out here
                    t_in[n_rows] = c;
                    for (int k = 0; k < 4; k++) begin
                        t_chk[n_rows][k] = (tk[k] != 64'h2d);
                        t_exp[n_rows][k] = hex_value(tk[k]);
                    end
                    n_rows = n_rows + 1;
                end
            end
        end
    endtask

    task automatic check_video(input int p);
        int s;
        s = (p + 2 < n_rows) ? p + 2 : n_rows - 1;  // Select uses state two rows on
        if (t_chk[p][0])
            check_value(32'(rgb_out), t_exp[p][0], "rgb_out");
        if (t_chk[p][1])
            check_value(32'(hsync_out), t_exp[p][1], "hsync_out");
        check_value(32'(hcount_out), t_in[p][0], "hcount_out");
        check_value(32'(vcount_out), t_in[p][1], "vcount_out");
        check_value(32'(vsync_out), t_in[p][3], "vsync_out");
        check_value(32'(hblnk_out), t_in[p][4], "hblnk_out");
        check_value(32'(vblnk_out), t_in[p][5], "vblnk_out");
        if (t_in[s][9] != 32'(game_pkg::KEEPER))
            check_value(32'(rgb_out), cursor_rule(p), "rgb_out against cursor rule");
    endtask

    initial begin
        int fd;
        fd = $fopen(TRACE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE);
            errors = errors + 1;
            report_and_finish();
        end else begin
            load_trace(fd);
            $fclose(fd);
            limit = n_rows + 20;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            for (int r = 0; r < n_rows + 3; r++) begin
                @(posedge clk);
                if (r < n_rows) begin
                    hcount_in    <= t_in[r][0][10:0];
                    vcount_in    <= t_in[r][1][10:0];
                    hsync_in     <= t_in[r][2][0];
                    vsync_in     <= t_in[r][3][0];
                    hblnk_in     <= t_in[r][4][0];
                    vblnk_in     <= t_in[r][5][0];
                    rgb_in       <= t_in[r][6][11:0];
                    xpos         <= t_in[r][7][11:0];
                    ypos         <= t_in[r][8][11:0];
                    game_state   <= game_pkg::g_state'(t_in[r][9][1:0]);
                    tx_full      <= t_in[r][10][0];
                    op_code_data <= t_in[r][11][2:0];
                end
                @(negedge clk);
                if (r < n_rows && t_chk[r][2])
                    check_value(32'(tx_wr), t_exp[r][2], "tx_wr");
                if (r < n_rows && t_chk[r][3])
                    check_value(32'(tx_data), t_exp[r][3], "tx_data");
                if (r >= 3) begin
                    check_video(r - 3);
                end else if (r < 2) begin
                    // Third cycle already shows the idle pixel taken after reset
                    check_value(32'(rgb_out), 32'h0, "rgb_out after reset");
                    check_value(32'(hcount_out), 32'h0, "hcount_out after reset");
                    check_value(32'(vcount_out), 32'h0, "vcount_out after reset");
                    check_value(32'(hsync_out), 32'h0, "hsync_out after reset");
                    check_value(32'(vsync_out), 32'h0, "vsync_out after reset");
                    check_value(32'(hblnk_out), 32'h0, "hblnk_out after reset");
                    check_value(32'(vblnk_out), 32'h0, "vblnk_out after reset");
                end
            end
            report_and_finish();
        end
    end

endmodule

// File: rtl/keeper_view_top.sv
/* Keeper view top level. The video stream is already timed and has no back-pressure;
   the UART, mouse decoder and game FSM sit outside this block */

`timescale 1ns/1ps

module keeper_view_top #(
    parameter int CURSOR_SIZE = 8,
    parameter int GLOVES_SIZE = 16   // 8 or 16 only
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::CNT_W-1:0] hcount_in,
    input  logic [game_pkg::CNT_W-1:0] vcount_in,
    input  logic                       hsync_in,
    input  logic                       vsync_in,
    input  logic                       hblnk_in,
    input  logic                       vblnk_in,
    input  logic [game_pkg::RGB_W-1:0] rgb_in,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic [game_pkg::POS_W-1:0] ypos,
    input  game_pkg::g_state           game_state,
    input  logic                       tx_full,
    input  logic [2:0]                 op_code_data,
    output logic [game_pkg::CNT_W-1:0] hcount_out,
    output logic [game_pkg::CNT_W-1:0] vcount_out,
    output logic                       hsync_out,
    output logic                       vsync_out,
    output logic                       hblnk_out,
    output logic                       vblnk_out,
    output logic [game_pkg::RGB_W-1:0] rgb_out,
    output logic [7:0]                 tx_data,
    output logic                       tx_wr
);

    vga_if in_if ();
    vga_if out_if ();

    assign in_if.hcount = hcount_in;
    assign in_if.vcount = vcount_in;
    assign in_if.hsync  = hsync_in;
    assign in_if.vsync  = vsync_in;
    assign in_if.hblnk  = hblnk_in;
    assign in_if.vblnk  = vblnk_in;
    assign in_if.rgb    = rgb_in;

    mouse_control #(
        .CURSOR_SIZE(CURSOR_SIZE),
        .GLOVES_SIZE(GLOVES_SIZE)
    ) u_mouse_control (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .game_state,
        .tx_full,
        .op_code_data,
        .in (in_if),
        .out(out_if),
        .tx_data,
        .tx_wr
    );

    assign hcount_out = out_if.hcount;
    assign vcount_out = out_if.vcount;
    assign hsync_out  = out_if.hsync;
    assign vsync_out  = out_if.vsync;
    assign hblnk_out  = out_if.hblnk;
    assign vblnk_out  = out_if.vblnk;
    assign rgb_out    = out_if.rgb;

endmodule

// File: rtl/mouse_control.sv
/* Picks the gloves overlay in KEEPER and the cursor otherwise, 3 cycles in total.
   Runs the keeper position sender beside the video path */

`timescale 1ns/1ps

module mouse_control #(
    parameter int CURSOR_SIZE = 8,
    parameter int GLOVES_SIZE = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic [game_pkg::POS_W-1:0] ypos,
    input  game_pkg::g_state           game_state,
    input  logic                       tx_full,
    input  logic [2:0]                 op_code_data,
    vga_if.in                          in,
    vga_if.out                         out,
    output logic [7:0]                 tx_data,
    output logic                       tx_wr
);

    logic keeper_sel;

    vga_if cursor_if ();
    vga_if gloves_if ();

    cursor_draw #(
        .CURSOR_SIZE(CURSOR_SIZE)
    ) u_cursor_draw (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .in (in),
        .out(cursor_if)
    );

    gloves_draw #(
        .GLOVES_SIZE(GLOVES_SIZE)
    ) u_gloves_draw (
        .clk,
        .rst,
        .xpos,
        .ypos,
        .in (in),
        .out(gloves_if)
    );

    keeper_pos_tx u_keeper_pos_tx (
        .clk,
        .rst,
        .xpos,
        .tx_full,
        .op_code_data,
        .tx_data,
        .tx_wr
    );

    assign keeper_sel = (game_state == game_pkg::KEEPER);

    // Output register, state change shows up one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= keeper_sel ? gloves_if.hcount : cursor_if.hcount;
            out.vcount <= keeper_sel ? gloves_if.vcount : cursor_if.vcount;
            out.hsync  <= keeper_sel ? gloves_if.hsync  : cursor_if.hsync;
            out.vsync  <= keeper_sel ? gloves_if.vsync  : cursor_if.vsync;
            out.hblnk  <= keeper_sel ? gloves_if.hblnk  : cursor_if.hblnk;
            out.vblnk  <= keeper_sel ? gloves_if.vblnk  : cursor_if.vblnk;
            out.rgb    <= keeper_sel ? gloves_if.rgb    : cursor_if.rgb;
        end
    end

    // Catches a stream that was never driven somewhere along the pipeline
    a_hcount_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out.hcount) && ({1'b0, out.hcount} < 12'd2048));

endmodule

// File: rtl/keeper_pos_tx.sv
/* Sends the clamped keeper x position as two tagged bytes, low half first.
   Every byte is written only after the previous one was taken (full rose, then fell) */

`timescale 1ns/1ps

module keeper_pos_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic                       tx_full,
    input  logic [2:0]                 op_code_data,
    output logic [7:0]                 tx_data,
    output logic                       tx_wr
);

    localparam int PW = game_pkg::POS_W;

    typedef enum logic [1:0] {WAIT_FULL, READY, SEND} pace_t;

    pace_t       state, state_nxt;
    logic [9:0]  xpos_clamp;
    logic [4:0]  hi_bits;     // Upper half of the last low-frame sample
    logic        half_hi;     // Next frame is the high half
    logic        resync;
    logic        resync_req;
    logic        load;
    logic        send_lo;

    always_comb begin
        xpos_clamp = (xpos > PW'(game_pkg::XPOS_MAX)) ? 10'(game_pkg::XPOS_MAX) : xpos[9:0];
        resync_req = !tx_full && (op_code_data == game_pkg::OP_RESYNC);
        load       = (state == READY) && !tx_full;
        send_lo    = !half_hi || resync || resync_req;
        tx_wr      = (state == SEND);
    end

    always_comb begin
        state_nxt = state;
        case (state)
            READY:     if (!tx_full) state_nxt = SEND;
            SEND:      state_nxt = WAIT_FULL;
            WAIT_FULL: if (tx_full) state_nxt = READY;  // Byte taken by the UART
            default:   state_nxt = READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= READY;
            half_hi <= 1'b0;
            resync  <= 1'b0;
            tx_data <= 8'h00;
        end else begin
            state <= state_nxt;
            if (load) begin
                if (send_lo) begin
                    tx_data <= {xpos_clamp[4:0], game_pkg::FRAME_LO_TAG};
                    half_hi <= 1'b1;
                    resync  <= 1'b0;
                end else begin
                    tx_data <= {hi_bits, game_pkg::FRAME_HI_TAG};
                    half_hi <= 1'b0;
                end
            end else if (resync_req) begin
                resync <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && send_lo)
            hi_bits <= xpos_clamp[9:5];
    end

    a_no_wr_when_full: assert property (@(posedge clk) disable iff (rst)
        tx_wr |-> !tx_full);

    a_tag_valid: assert property (@(posedge clk) disable iff (rst)
        tx_wr |-> (tx_data[2:0] == game_pkg::FRAME_LO_TAG ||
                   tx_data[2:0] == game_pkg::FRAME_HI_TAG));

endmodule

// File: rtl/gloves_draw.sv
/* Gloves sprite overlay at (xpos, ypos), 2 cycles of latency.
   GLOVES_SIZE must be 8 or 16; size 8 shows the top-left quarter of the mask */

`timescale 1ns/1ps

module gloves_draw #(
    parameter int GLOVES_SIZE = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic [game_pkg::POS_W-1:0] ypos,
    vga_if.in                          in,
    vga_if.out                         out
);

    localparam int AW = game_pkg::POS_W + 1;

    // Two gloves, columns 1..6 and 9..14, rows 2..13
    localparam logic [15:0] MASK [16] = '{
        16'h0000, 16'h0000, 16'h7E7E, 16'h7E7E,
        16'h7E7E, 16'h7E7E, 16'h7E7E, 16'h7E7E,
        16'h7E7E, 16'h7E7E, 16'h7E7E, 16'h7E7E,
        16'h7E7E, 16'h7E7E, 16'h0000, 16'h0000
    };

    logic [AW-1:0] dx, dy;  // Position inside the sprite box
    logic          in_box;
    logic          mask_bit;

    logic [game_pkg::CNT_W-1:0] hcount_q, vcount_q;
    logic                       hsync_q, vsync_q, hblnk_q, vblnk_q;
    logic [game_pkg::RGB_W-1:0] rgb_q;
    logic                       inside_q, mask_q;

    always_comb begin
        dx       = AW'(in.hcount) - AW'(xpos);
        dy       = AW'(in.vcount) - AW'(ypos);
        in_box   = (AW'(in.hcount) >= AW'(xpos)) && (dx < AW'(GLOVES_SIZE)) &&
                   (AW'(in.vcount) >= AW'(ypos)) && (dy < AW'(GLOVES_SIZE));
        mask_bit = MASK[dy[3:0]][dx[3:0]];
    end

    // Stage 1: mask read and box flag
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_q <= '0;
            vcount_q <= '0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            hblnk_q  <= 1'b0;
            vblnk_q  <= 1'b0;
            rgb_q    <= '0;
            inside_q <= 1'b0;
            mask_q   <= 1'b0;
        end else begin
            hcount_q <= in.hcount;
            vcount_q <= in.vcount;
            hsync_q  <= in.hsync;
            vsync_q  <= in.vsync;
            hblnk_q  <= in.hblnk;
            vblnk_q  <= in.vblnk;
            rgb_q    <= in.rgb;
            inside_q <= in_box;
            mask_q   <= mask_bit;
        end
    end

    // Stage 2: paint
    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= hcount_q;
            out.vcount <= vcount_q;
            out.hsync  <= hsync_q;
            out.vsync  <= vsync_q;
            out.hblnk  <= hblnk_q;
            out.vblnk  <= vblnk_q;
            if (inside_q && mask_q && !hblnk_q && !vblnk_q)
                out.rgb <= game_pkg::GLOVES_RGB;
            else
                out.rgb <= rgb_q;
        end
    end

    // The registered box flag must stay aligned with the row of the registered pixel
    a_row_in_box: assert property (@(posedge clk) disable iff (rst)
        inside_q |-> ((AW'(vcount_q) - AW'($past(ypos))) < AW'(GLOVES_SIZE)));

endmodule

// File: rtl/cursor_draw.sv
/* Square cursor overlay, top-left corner at (xpos, ypos). Latency is 2 cycles
   to line up with the gloves path; blanked pixels are never painted */

`timescale 1ns/1ps

module cursor_draw #(
    parameter int CURSOR_SIZE = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::POS_W-1:0] xpos,
    input  logic [game_pkg::POS_W-1:0] ypos,
    vga_if.in                          in,
    vga_if.out                         out
);

    localparam int AW = game_pkg::POS_W + 1;  // One spare bit for xpos + size

    logic [AW-1:0] h_ext, v_ext;
    logic [AW-1:0] x_end, y_end;
    logic          hit;

    logic [game_pkg::CNT_W-1:0] hcount_q, vcount_q;
    logic                       hsync_q, vsync_q, hblnk_q, vblnk_q;
    logic [game_pkg::RGB_W-1:0] rgb_q;

    always_comb begin
        h_ext = AW'(in.hcount);
        v_ext = AW'(in.vcount);
        x_end = AW'(xpos) + AW'(CURSOR_SIZE);
        y_end = AW'(ypos) + AW'(CURSOR_SIZE);
        hit   = (h_ext >= AW'(xpos)) && (h_ext < x_end) &&
                (v_ext >= AW'(ypos)) && (v_ext < y_end) &&
                !in.hblnk && !in.vblnk;
    end

    // Drawing register
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_q <= '0;
            vcount_q <= '0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            hblnk_q  <= 1'b0;
            vblnk_q  <= 1'b0;
            rgb_q    <= '0;
        end else begin
            hcount_q <= in.hcount;
            vcount_q <= in.vcount;
            hsync_q  <= in.hsync;
            vsync_q  <= in.vsync;
            hblnk_q  <= in.hblnk;
            vblnk_q  <= in.vblnk;
            rgb_q    <= hit ? game_pkg::CURSOR_RGB : in.rgb;
        end
    end

    // Alignment register, matches the gloves address stage
    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= hcount_q;
            out.vcount <= vcount_q;
            out.hsync  <= hsync_q;
            out.vsync  <= vsync_q;
            out.hblnk  <= hblnk_q;
            out.vblnk  <= vblnk_q;
            out.rgb    <= rgb_q;
        end
    end

endmodule

// File: rtl/vga_if.sv
/* Timed VGA pixel stream. All fields of one pixel travel in the same cycle */

`timescale 1ns/1ps

interface vga_if;

    logic [game_pkg::CNT_W-1:0] hcount;
    logic [game_pkg::CNT_W-1:0] vcount;
    logic                       hsync;
    logic                       vsync;
    logic                       hblnk;
    logic                       vblnk;
    logic [game_pkg::RGB_W-1:0] rgb;

    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

// File: rtl/game_pkg.sv
/* Shared game types and constants for the keeper view block.
   Colors are 4:4:4 RGB, and the sent keeper position never exceeds 10 bits */

package game_pkg;

    // Game phase as driven by the game FSM
    typedef enum logic [1:0] {
        MENU,
        SHOOTER,
        KEEPER,
        RESULT
    } g_state;

    // VGA stream widths
    parameter int CNT_W = 11;
    parameter int RGB_W = 12;

    // Mouse coordinate width and clamp for the sent position
    parameter int POS_W    = 12;
    parameter int XPOS_MAX = 1023;

    // UART frame tags, low three bits of every byte
    parameter logic [2:0] FRAME_LO_TAG = 3'b001;  // Carries xpos[4:0]
    parameter logic [2:0] FRAME_HI_TAG = 3'b010;  // Carries xpos[9:5]

    // Opcode from the other board asking for a fresh low frame
    parameter logic [2:0] OP_RESYNC = 3'b111;

    parameter logic [RGB_W-1:0] CURSOR_RGB = 12'hFFF;
    parameter logic [RGB_W-1:0] GLOVES_RGB = 12'hFA0;

endpackage
